// ==== common/mdio_pkg.sv ====
// Shared widths, frame constants and sequencer states for the MDIO management controller
package mdio_pkg;

	////////////////////////////////////////
	// Field widths
	////////////////////////////////////////

	// Register address inside the PHY
	typedef logic [4:0] reg_addr_t;

	// PHY address on the MDIO bus
	typedef logic [4:0] phy_addr_t;

	// One MDIO data word, also one half of a frame
	typedef logic [15:0] mdio_word_t;

	// Wishbone data word
	typedef logic [31:0] bus_word_t;

	// Shifter bit position, wide enough for the preamble count
	typedef logic [5:0] bit_pos_t;

	////////////////////////////////////////
	// Frame constants
	////////////////////////////////////////

	// Ones sent after reset before the first frame
	localparam int PREAMBLE_BITS = 64;

	// Start and opcode nibbles of a clause-22 frame
	localparam logic [3:0] OP_READ = 4'b0110;
	localparam logic [3:0] OP_WRITE = 4'b0101;

	// Frame halves
	localparam int HEADER_BITS = 16;
	localparam int DATA_BITS = 16;

	////////////////////////////////////////
	// Sequencer states
	////////////////////////////////////////

	typedef enum logic [2:0] {
		ST_RESET,
		ST_IDLE,
		ST_ADDRESS,
		ST_READ,
		ST_WRITE
	} seq_state_t;

endpackage

// ==== common/mdio_req_if.sv ====
// One pending register access from the Wishbone front end to the sequencer, with its completion
`timescale 1ns/100ps

interface mdio_req_if;
	import mdio_pkg::*;

	// Request side, held stable while pending is high
	logic pending;
	logic write;
	reg_addr_t reg_addr;
	mdio_word_t wdata;

	// Completion side, rdata valid with done
	logic done;
	mdio_word_t rdata;

	modport port (
		output pending,
		output write,
		output reg_addr,
		output wdata,
		input done,
		input rdata
	);

	modport seq (
		input pending,
		input write,
		input reg_addr,
		input wdata,
		output done,
		output rdata
	);

endinterface

// ==== common/mdio_bit_if.sv ====
// Word loads from the frame sequencer to the serial shifter, and bit timing back
`timescale 1ns/100ps

interface mdio_bit_if;
	import mdio_pkg::*;

	// Word load, taken in place of a shift
	logic load;
	mdio_word_t load_word;
	bit_pos_t next_pos;

	// Bit timing and receive data
	logic bit_tick;
	logic word_end;
	mdio_word_t rx_word;

	modport seq (
		output load,
		output load_word,
		output next_pos,
		input bit_tick,
		input word_end,
		input rx_word
	);

	modport shift (
		input load,
		input load_word,
		input next_pos,
		output bit_tick,
		output word_end,
		output rx_word
	);

endinterface

// ==== rtl/mdio_bus_port.sv ====
// Wishbone slave front end, holds one MDIO request and stalls the bus until it completes
`timescale 1ns/100ps

module mdio_bus_port (
	input logic i_clk,
	input logic i_reset,
	input logic i_wb_cyc,
	input logic i_wb_stb,
	input logic i_wb_we,
	input mdio_pkg::reg_addr_t i_wb_addr,
	input mdio_pkg::bus_word_t i_wb_data,
	output logic o_wb_stall,
	output logic o_wb_ack,
	output mdio_pkg::bus_word_t o_wb_data,
	mdio_req_if.port req
);
	import mdio_pkg::*;

	logic accept;
	logic idle_seen;
	logic pre_ack;
	mdio_word_t rdata_q;

	assign accept = i_wb_stb && !o_wb_stall;

	// Request latch
	always_ff @(posedge i_clk)
	begin
		if (accept)
		begin
			req.write <= i_wb_we;
			req.reg_addr <= i_wb_addr;
			req.wdata <= i_wb_data[DATA_BITS-1:0];
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (req.done)
			rdata_q <= req.rdata;
	end

	assign o_wb_data = {{($bits(bus_word_t) - DATA_BITS){1'b0}}, rdata_q};

	////////////////////////////////////////
	// Handshake control
	////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			req.pending <= 1'b0;
			idle_seen <= 1'b0;
			o_wb_stall <= 1'b1;
			pre_ack <= 1'b0;
			o_wb_ack <= 1'b0;
		end
		else
		begin
			if (accept)
				req.pending <= 1'b1;
			else if (req.done)
				req.pending <= 1'b0;

			// First done marks the end of the preamble
			if (req.done)
				idle_seen <= 1'b1;

			// Falls the clock after ack, or after done when no ack is due
			o_wb_stall <= accept || req.pending || !idle_seen;

			// An abandoned cycle loses its ack
			if (!i_wb_cyc)
				pre_ack <= 1'b0;
			else if (accept)
				pre_ack <= 1'b1;
			else if (req.done)
				pre_ack <= 1'b0;

			o_wb_ack <= req.done && req.pending && pre_ack && i_wb_cyc;
		end
	end

endmodule

// ==== rtl/mdio/mdio_sequencer.sv ====
// Clause-22 frame state machine, builds header and data loads and sets the MDIO drive direction
`timescale 1ns/100ps

module mdio_sequencer #(
	parameter mdio_pkg::phy_addr_t PHY_ADDR = 5'd1
) (
	input logic i_clk,
	input logic i_reset,
	mdio_req_if.seq req,
	mdio_bit_if.seq bits,
	output logic o_mdwe
);
	import mdio_pkg::*;

	// A read header stops before the turnaround, which then runs with the data phase
	localparam bit_pos_t HDR_POS_WR = bit_pos_t'(HEADER_BITS - 1);
	localparam bit_pos_t HDR_POS_RD = bit_pos_t'(HEADER_BITS - 2);
	localparam bit_pos_t DAT_POS_WR = bit_pos_t'(DATA_BITS);
	localparam bit_pos_t DAT_POS_RD = bit_pos_t'(DATA_BITS + 1);

	seq_state_t state;
	mdio_word_t header;

	always_comb
	begin
		if (req.write)
			header = {OP_WRITE, PHY_ADDR, req.reg_addr, 2'b10};
		else
			header = {OP_READ, PHY_ADDR, req.reg_addr, 2'b11};
	end

	////////////////////////////////////////
	// Shifter loads
	////////////////////////////////////////

	always_comb
	begin
		bits.load = 1'b0;
		bits.load_word = header;
		bits.next_pos = HDR_POS_WR;
		case (state)
			ST_IDLE:
			begin
				if (bits.bit_tick && req.pending)
				begin
					bits.load = 1'b1;
					bits.next_pos = req.write ? HDR_POS_WR : HDR_POS_RD;
				end
			end
			ST_ADDRESS:
			begin
				// Read data phase shifts out ones while the PHY drives
				if (bits.word_end)
				begin
					bits.load = 1'b1;
					bits.load_word = req.write ? req.wdata : '1;
					bits.next_pos = req.write ? DAT_POS_WR : DAT_POS_RD;
				end
			end
			default:
			begin
			end
		endcase
	end

	assign req.rdata = bits.rx_word;

	////////////////////////////////////////
	// State register
	////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			state <= ST_RESET;
			req.done <= 1'b0;
			o_mdwe <= 1'b1;
		end
		else
		begin
			req.done <= 1'b0;
			case (state)
				ST_RESET:
				begin
					// End of preamble, reported as a done without a request
					if (bits.word_end)
					begin
						state <= ST_IDLE;
						req.done <= 1'b1;
					end
				end
				ST_IDLE:
				begin
					if (bits.bit_tick && req.pending)
						state <= ST_ADDRESS;
				end
				ST_ADDRESS:
				begin
					if (bits.word_end)
					begin
						state <= req.write ? ST_WRITE : ST_READ;
						o_mdwe <= req.write;
					end
				end
				ST_READ, ST_WRITE:
				begin
					if (bits.word_end)
					begin
						state <= ST_IDLE;
						req.done <= 1'b1;
						o_mdwe <= 1'b1;
					end
				end
				default:
					state <= ST_RESET;
			endcase
		end
	end

endmodule

// ==== rtl/mdio/mdio_shifter.sv ====
// MDC divider and MDIO serial shifter, with bit strobe, receive sampling and position counter
`timescale 1ns/100ps

module mdio_shifter #(
	parameter int CLK_BITS = 2
) (
	input logic i_clk,
	input logic i_reset,
	mdio_bit_if.shift bits,
	input logic i_mdio,
	output logic o_mdc,
	output logic o_mdio
);
	import mdio_pkg::*;

	// Strobe is set one count before wrap so it lines up with the MDC fall
	localparam logic [CLK_BITS-1:0] TICK_AT = CLK_BITS'((1 << CLK_BITS) - 2);

	logic [CLK_BITS-1:0] clk_count;
	logic tick;
	mdio_word_t tx_reg;
	mdio_word_t rx_reg;
	bit_pos_t bit_pos;

	////////////////////////////////////////
	// MDC and bit strobe
	////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			clk_count <= '0;
			tick <= 1'b0;
		end
		else
		begin
			clk_count <= clk_count + 1'b1;
			tick <= (clk_count == TICK_AT);
		end
	end

	assign o_mdc = clk_count[CLK_BITS-1];
	assign bits.bit_tick = tick;
	assign bits.word_end = tick && (bit_pos == '0);

	////////////////////////////////////////
	// Transmit side and bit position
	////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			// Preamble of ones
			tx_reg <= '1;
			o_mdio <= 1'b1;
			bit_pos <= bit_pos_t'(PREAMBLE_BITS - 1);
		end
		else
		begin
			if (tick)
				o_mdio <= tx_reg[DATA_BITS-1];

			if (bits.load)
			begin
				tx_reg <= bits.load_word;
				bit_pos <= bits.next_pos;
			end
			else if (tick)
			begin
				tx_reg <= {tx_reg[DATA_BITS-2:0], 1'b1};
				if (bit_pos != '0)
					bit_pos <= bit_pos - 1'b1;
			end
		end
	end

	// Sampled just before MDC falls, PHY changes after the rise
	always_ff @(posedge i_clk)
	begin
		if (tick)
			rx_reg <= {rx_reg[DATA_BITS-2:0], i_mdio};
	end

	assign bits.rx_word = rx_reg;

endmodule

// ==== rtl/mdio_ctrl.sv ====
// MDIO management controller top level, Wishbone slave in and MDC and MDIO out to the PHY
`timescale 1ns/100ps

module mdio_ctrl #(
	parameter int CLK_BITS = 2,
	parameter mdio_pkg::phy_addr_t PHY_ADDR = 5'd1
) (
	input logic i_clk,
	input logic i_reset,
	input logic i_wb_cyc,
	input logic i_wb_stb,
	input logic i_wb_we,
	input mdio_pkg::reg_addr_t i_wb_addr,
	input mdio_pkg::bus_word_t i_wb_data,
	output logic o_wb_stall,
	output logic o_wb_ack,
	output mdio_pkg::bus_word_t o_wb_data,
	output logic o_mdc,
	output logic o_mdio,
	output logic o_mdwe,
	input logic i_mdio
);

	mdio_req_if req_bus ();
	mdio_bit_if bit_bus ();

	mdio_bus_port u_bus_port (
		.i_clk (i_clk),
		.i_reset (i_reset),
		.i_wb_cyc (i_wb_cyc),
		.i_wb_stb (i_wb_stb),
		.i_wb_we (i_wb_we),
		.i_wb_addr (i_wb_addr),
		.i_wb_data (i_wb_data),
		.o_wb_stall (o_wb_stall),
		.o_wb_ack (o_wb_ack),
		.o_wb_data (o_wb_data),
		.req (req_bus.port)
	);

	mdio_sequencer #(
		.PHY_ADDR (PHY_ADDR)
	) u_sequencer (
		.i_clk (i_clk),
		.i_reset (i_reset),
		.req (req_bus.seq),
		.bits (bit_bus.seq),
		.o_mdwe (o_mdwe)
	);

	mdio_shifter #(
		.CLK_BITS (CLK_BITS)
	) u_shifter (
		.i_clk (i_clk),
		.i_reset (i_reset),
		.bits (bit_bus.shift),
		.i_mdio (i_mdio),
		.o_mdc (o_mdc),
		.o_mdio (o_mdio)
	);

endmodule

// ==== dv/mdio_ctrl_assertions.sv ====
// Bound protocol checker for the MDIO controller, decodes frames and asserts timing and content
`timescale 1ns/100ps

module mdio_ctrl_assertions (
	input logic i_clk,
	input logic i_reset,
	input logic i_wb_cyc,
	input logic i_wb_stb,
	input logic i_wb_we,
	input mdio_pkg::reg_addr_t i_wb_addr,
	input mdio_pkg::bus_word_t i_wb_data,
	input logic o_wb_stall,
	input logic o_wb_ack,
	input mdio_pkg::bus_word_t o_wb_data,
	input logic o_mdc,
	input logic o_mdio,
	input logic o_mdwe
);
	import mdio_pkg::*;

	int errors = 0;
	int pre_falls;
	int dec_cnt;
	logic [7:0] since_fall;
	logic mdc_q, mdio_q, seen_fall, preamble, rd_flag, frame_done, owed, lat_we;
	logic [31:0] frame;
	reg_addr_t lat_addr;
	mdio_word_t lat_data;
	mdio_word_t shadow [32];
	logic fall_now, rise_now;

	assign fall_now = mdc_q && !o_mdc;
	assign rise_now = !mdc_q && o_mdc;

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			{mdc_q, seen_fall, rd_flag, frame_done, owed, lat_we} <= '0;
			{mdio_q, preamble} <= 2'b11;
			since_fall <= '0;
			pre_falls <= 0;
			dec_cnt <= 0;
			frame <= '0;
			for (int i = 0; i < 32; i++)
				shadow[i] <= mdio_word_t'(i) ^ 16'hA5A0;
		end
		else
		begin
			mdc_q <= o_mdc;
			mdio_q <= o_mdio;
			since_fall <= fall_now ? 8'd0 : since_fall + 8'd1;
			if (fall_now)
				seen_fall <= 1'b1;
			if (fall_now && preamble)
				pre_falls <= pre_falls + 1;
			if (!o_wb_stall)
				preamble <= 1'b0;
			// Frame decode on rising MDC, start bit is the first zero
			frame_done <= 1'b0;
			if (rise_now && dec_cnt == 0 && !o_mdio)
			begin
				dec_cnt <= 1;
				frame <= '0;
				rd_flag <= 1'b0;
			end
			else if (rise_now && dec_cnt != 0)
			begin
				frame <= {frame[30:0], o_mdio};
				if (dec_cnt == 13)
					rd_flag <= (frame[10:9] == 2'b10);
				dec_cnt <= (dec_cnt == 31) ? 0 : dec_cnt + 1;
				frame_done <= (dec_cnt == 31);
			end
			if (frame_done && lat_we)
				shadow[frame[22:18]] <= frame[15:0];
			if (i_wb_stb && !o_wb_stall)
			begin
				owed <= 1'b1;
				{lat_we, lat_addr, lat_data} <= {i_wb_we, i_wb_addr, i_wb_data[15:0]};
			end
			else if (o_wb_ack || !i_wb_cyc)
				owed <= 1'b0;
		end
	end

	////////////////////////////////////////
	// Preamble and MDC timing
	////////////////////////////////////////

	a_preamble_lines: assert property (@(posedge i_clk) disable iff (i_reset)
		preamble |-> (o_mdwe && o_mdio))
		else begin errors++; $error("MDIO or MDWE dropped during the preamble"); end
	a_preamble_len: assert property (@(posedge i_clk) disable iff (i_reset)
		(preamble && !o_wb_stall) |-> (pre_falls == PREAMBLE_BITS))
		else begin errors++; $error("** Error preamble expected %0d actual %0d",
			PREAMBLE_BITS, pre_falls); end
	a_mdio_edge: assert property (@(posedge i_clk) disable iff (i_reset)
		(o_mdio != mdio_q) |-> fall_now)
		else begin errors++; $error("MDIO changed away from an MDC fall"); end
	a_mdc_period: assert property (@(posedge i_clk) disable iff (i_reset)
		(fall_now && seen_fall) |-> (since_fall == 8'd3))
		else begin errors++; $error("** Error mdc_period expected 4 actual %0d",
			since_fall + 1); end

	////////////////////////////////////////
	// Frame content and read data
	////////////////////////////////////////

	a_write_frame: assert property (@(posedge i_clk) disable iff (i_reset)
		(frame_done && lat_we) |-> (frame == {OP_WRITE, 5'd1, lat_addr, 2'b10, lat_data}))
		else begin errors++; $error("** Error write_frame expected %h actual %h",
			{OP_WRITE, 5'd1, lat_addr, 2'b10, lat_data}, frame); end
	a_read_header: assert property (@(posedge i_clk) disable iff (i_reset)
		(frame_done && !lat_we) |-> (frame[31:18] == {OP_READ, 5'd1, lat_addr}))
		else begin errors++; $error("** Error read_header expected %h actual %h",
			{OP_READ, 5'd1, lat_addr}, frame[31:18]); end
	a_read_mdwe: assert property (@(posedge i_clk) disable iff (i_reset)
		(rise_now && rd_flag && dec_cnt >= 14) |-> !o_mdwe)
		else begin errors++; $error("MDWE high during read turnaround or data"); end
	a_read_data: assert property (@(posedge i_clk) disable iff (i_reset)
		(o_wb_ack && !lat_we) |-> (o_wb_data == {16'h0, shadow[lat_addr]}))
		else begin errors++; $error("** Error read_data expected %h actual %h",
			{16'h0, shadow[lat_addr]}, o_wb_data); end

	////////////////////////////////////////
	// Bus handshake
	////////////////////////////////////////

	a_ack_owed: assert property (@(posedge i_clk) disable iff (i_reset)
		o_wb_ack |-> owed)
		else begin errors++; $error("Ack without an outstanding request"); end
	a_ack_single: assert property (@(posedge i_clk) disable iff (i_reset)
		o_wb_ack |=> !o_wb_ack)
		else begin errors++; $error("Ack held longer than one clock"); end
	a_stall_held: assert property (@(posedge i_clk) disable iff (i_reset)
		(owed && !o_wb_ack) |-> o_wb_stall)
		else begin errors++; $error("Stall fell before the ack"); end

endmodule

bind mdio_ctrl mdio_ctrl_assertions u_assertions (.*);

// ==== dv/mdio_ctrl_tb.sv ====
// Simulation top that drives Wishbone accesses into the MDIO controller against a PHY register model
`timescale 1ns/100ps

module mdio_ctrl_tb;
	import mdio_pkg::*;

	localparam int STALL_TIMEOUT = 600;
	localparam int ACK_TIMEOUT = 400;

	logic i_clk = 1'b0;
	logic i_reset = 1'b1;
	logic i_wb_cyc = 1'b0;
	logic i_wb_stb = 1'b0;
	logic i_wb_we = 1'b0;
	reg_addr_t i_wb_addr = '0;
	bus_word_t i_wb_data = '0;
	logic i_mdio = 1'b1;
	logic o_wb_stall, o_wb_ack, o_mdc, o_mdio, o_mdwe;
	bus_word_t o_wb_data;

	logic [31:0] lcg_state = 32'd66962;
	int timeouts = 0;
	int tests = 0;
	int failed = 0;
	int err_mark = 0;
	int to_mark = 0;
	mdio_word_t phy_regs [32];
	int phy_cnt = 0;
	logic [31:0] phy_frame;
	reg_addr_t phy_reg = '0;
	logic phy_read = 1'b0;
	logic phy_drive = 1'b0;
	logic [31:0] r;

	always #2 i_clk = ~i_clk;

	mdio_ctrl UUT (.*);

	initial
	begin
		for (int i = 0; i < 32; i++)
			phy_regs[i] = mdio_word_t'(i) ^ 16'hA5A0;
	end

	// PHY model that decodes on rising MDC and drives read data after the turnaround
	always @(posedge o_mdc)
	begin
		#1;
		if (phy_cnt == 0)
		begin
			phy_drive = 1'b0;
			if (o_mdio === 1'b0)
			begin
				phy_cnt = 1;
				phy_frame = '0;
			end
		end
		else
		begin
			phy_frame = {phy_frame[30:0], o_mdio};
			phy_cnt++;
			if (phy_cnt == 14)
			begin
				phy_read = (phy_frame[11:10] == 2'b10);
				phy_reg = phy_frame[4:0];
			end
			if (phy_read && phy_cnt >= 17)
			begin
				phy_drive = 1'b1;
				i_mdio = phy_regs[phy_reg][32 - phy_cnt];
			end
			if (phy_cnt == 32)
			begin
				if (!phy_read)
					phy_regs[phy_frame[22:18]] = phy_frame[15:0];
				phy_cnt = 0;
			end
		end
		if (!phy_drive)
			i_mdio = o_mdio;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic wait_stall_low();
		int n = 0;
		while (o_wb_stall && n < STALL_TIMEOUT)
		begin
			@(posedge i_clk);
			#1;
			n++;
		end
		if (o_wb_stall)
		begin
			timeouts++;
			$display("Timeout: stall did not fall");
		end
	endtask

	// Holds the strobe until the request is taken, then releases it
	task automatic issue_request(input logic we, input reg_addr_t addr, input mdio_word_t data);
		{i_wb_cyc, i_wb_stb, i_wb_we, i_wb_addr} = {1'b1, 1'b1, we, addr};
		i_wb_data = {16'h0, data};
		wait_stall_low();
		@(posedge i_clk);
		#1;
		i_wb_stb = 1'b0;
	endtask

	task automatic bus_access(input logic we, input reg_addr_t addr, input mdio_word_t data);
		int n = 0;
		issue_request(we, addr, data);
		while (!o_wb_ack && n < ACK_TIMEOUT)
		begin
			@(posedge i_clk);
			#1;
			n++;
		end
		if (!o_wb_ack)
		begin
			timeouts++;
			$display("Timeout: no ack for access to register %0d", addr);
		end
		i_wb_cyc = 1'b0;
	endtask

	task automatic finish_test(input string name);
		int errs;
		int tos;
		errs = UUT.u_assertions.errors - err_mark;
		tos = timeouts - to_mark;
		tests++;
		if (errs != 0 || tos != 0)
		begin
			failed++;
			$display("%s: failed, %0d assertion errors, %0d timeouts", name, errs, tos);
		end
		else
			$display("%s: passed", name);
		err_mark = UUT.u_assertions.errors;
		to_mark = timeouts;
	endtask

	initial
	begin
		repeat (3) @(posedge i_clk);
		#1;
		i_reset = 1'b0;
		wait_stall_low();
		finish_test("reset_preamble");

		for (int i = 0; i < 8; i++)
		begin
			r = lcg_next();
			bus_access(1'b1, r[20:16], r[15:0]);
		end
		finish_test("write_frames");

		for (int i = 0; i < 8; i++)
		begin
			r = lcg_next();
			bus_access(1'b0, r[20:16], 16'h0);
		end
		finish_test("read_frames");

		for (int i = 0; i < 12; i++)
		begin
			r = lcg_next();
			bus_access(r[24], r[20:16], r[15:0]);
		end
		finish_test("mixed_access");

		// Cycle dropped partway into a write frame
		r = lcg_next();
		issue_request(1'b1, r[20:16], r[15:0]);
		repeat (40) @(posedge i_clk);
		#1;
		i_wb_cyc = 1'b0;
		wait_stall_low();
		bus_access(1'b0, r[20:16], 16'h0);
		finish_test("abandoned_cycle");

		repeat (4) @(posedge i_clk);
		$display("tests %0d, failed %0d, assertion errors %0d, timeouts %0d",
			tests, failed, UUT.u_assertions.errors, timeouts);
		if (failed == 0 && UUT.u_assertions.errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// ==== mdio_ctrl.f ====
common/mdio_pkg.sv
common/mdio_req_if.sv
common/mdio_bit_if.sv
rtl/mdio_bus_port.sv
rtl/mdio/mdio_sequencer.sv
rtl/mdio/mdio_shifter.sv
rtl/mdio_ctrl.sv
dv/mdio_ctrl_assertions.sv
dv/mdio_ctrl_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = mdio_ctrl_tb
FILELIST = mdio_ctrl.f
LOG = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	-./obj_dir/$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
